//--- src/erx_cfg.svh
// eLink receiver widths, register map and packet field positions
`ifndef ERX_CFG_SVH
`define ERX_CFG_SVH

// Beat geometry at the divided link clock
`define ERX_BEAT_W      64      // Data bits per beat
`define ERX_FRAME_W     8       // One frame bit per byte slot
`define ERX_LANES       8       // Raw lane levels for GPIO sampling
`define ERX_ADDR_W      32      // Packet address width

// Configuration port
`define ERX_REG_ADDR_W  2
`define ERX_REG_CTRL    2'd0    // Enable, gpio_mode, dataout
`define ERX_REG_STATUS  2'd1    // Sticky framing error in bit 0
`define ERX_REG_DATAIN  2'd2    // GPIO readback, read only
`define ERX_REG_PKTCNT  2'd3    // Received packet count
`define ERX_PKTCNT_W    16

// Head beat fields
`define ERX_CTRL_MSB    63
`define ERX_CTRL_LSB    56
`define ERX_DST_MSB     55
`define ERX_DST_LSB     24
// Body beat fields
`define ERX_DATA_MSB    63
`define ERX_DATA_LSB    32
`define ERX_SRC_MSB     31
`define ERX_SRC_LSB     0

`endif

//--- src/erx_link_pkg.sv
// eLink receiver link-side types for deserialized beats, frames and lane levels
`default_nettype none

`include "erx_cfg.svh"

package erx_link_pkg;

   //########################################
   // Beat contents
   //########################################

   // Frame bit per byte slot, bit 0 is the first byte on the wire
   typedef logic [`ERX_FRAME_W-1:0] frame_t;

   // Eight bytes of link data per divided clock
   typedef logic [`ERX_BEAT_W-1:0] beat_data_t;

   //########################################
   // GPIO readback
   //########################################

   typedef logic [`ERX_LANES-1:0] lane_t;   // Raw lane levels

   // Frame bit sits above the lanes
   typedef logic [`ERX_LANES:0] gpio_in_t;

   //########################################
   // One beat as it travels through the receiver
   //########################################

   typedef struct packed {
      frame_t     frame;   // Upper 8 bits
      beat_data_t data;    // Lower 64 bits
   } rx_beat_t;            // 72 bits

endpackage

`default_nettype wire

//--- src/erx_xact_pkg.sv
// eLink receiver transaction and configuration types, packets and decoder states
`default_nettype none

`include "erx_cfg.svh"

package erx_xact_pkg;

   //########################################
   // Packet fields
   //########################################

   typedef logic [`ERX_ADDR_W-1:0] addr_t;
   typedef logic [31:0] word_t;   // Data word, also the config bus width

   // Bit 0 write, bits 3:2 datamode, rest passed through untouched
   typedef logic [7:0] ctrl_t;

   typedef struct packed {
      ctrl_t ctrl;      // From head beat
      addr_t dstaddr;   // From head beat
      word_t data;      // From body beat
      addr_t srcaddr;   // From body beat
   } erx_packet_t;      // 104 bits

   // Decoder position within a head and body pair
   typedef enum logic [1:0] {
      DEC_IDLE,         // Waiting for a rising frame
      DEC_HEAD,         // Head latched, body expected next
      DEC_BODY          // Packet done, frame may continue a burst
   } dec_state_t;

   //########################################
   // Configuration
   //########################################

   typedef logic [`ERX_REG_ADDR_W-1:0] reg_addr_t;

   // Laid out as CTRL bits 3:0
   typedef struct packed {
      logic [1:0] dataout;     // Bit 1 wr_wait, bit 0 rd_wait in GPIO mode
      logic       gpio_mode;   // Bit 1
      logic       rx_enable;   // Bit 0
   } rx_ctrl_t;

endpackage

`default_nettype wire

//--- src/erx_ecfg.sv
// eLink receiver configuration block with control, sticky status, GPIO readback and packet count
`timescale 1ns/100ps
`default_nettype none

`include "erx_cfg.svh"

module erx_ecfg
   import erx_link_pkg::*;
   import erx_xact_pkg::*;
(
   input  wire       rx_lclk_div4,
   input  wire       rxreset,
   input  wire       cfg_write,   // Single-cycle write strobe
   input  reg_addr_t cfg_addr,
   input  word_t     cfg_wdata,
   output word_t     cfg_rdata,   // Combinational read
   input  gpio_in_t  datain,      // Sampled lanes and frame bit
   input  wire       pkt_valid,
   input  wire       frame_err,
   output rx_ctrl_t  ctrl
);

   logic                     err_flag;   // Sticky framing error
   logic [`ERX_PKTCNT_W-1:0] pkt_cnt;

   // Write decode
   wire ctrl_we   = cfg_write & (cfg_addr == `ERX_REG_CTRL);
   wire status_we = cfg_write & (cfg_addr == `ERX_REG_STATUS);
   wire pktcnt_we = cfg_write & (cfg_addr == `ERX_REG_PKTCNT);

   //########################################
   // Registers
   //########################################

   always_ff @(posedge rx_lclk_div4 or posedge rxreset)
   begin
      if (rxreset)
         ctrl <= '0;                              // Disabled, fabric waits
      else if (ctrl_we)
         ctrl <= rx_ctrl_t'(cfg_wdata[3:0]);
   end

   always_ff @(posedge rx_lclk_div4 or posedge rxreset)
   begin
      if (rxreset)
         err_flag <= 1'b0;
      else if (frame_err)
         err_flag <= 1'b1;                        // New error beats a clear
      else if (status_we && cfg_wdata[0])
         err_flag <= 1'b0;                        // Write one to clear
   end

   always_ff @(posedge rx_lclk_div4 or posedge rxreset)
   begin
      if (rxreset)
         pkt_cnt <= '0;
      else if (pktcnt_we)
         pkt_cnt <= '0;                           // Any value clears
      else if (pkt_valid)
         pkt_cnt <= pkt_cnt + 1'b1;               // Wraps
   end

   //########################################
   // Read mux
   //########################################

   always_comb
   begin
      case (cfg_addr)
         `ERX_REG_CTRL   : cfg_rdata = word_t'(ctrl);
         `ERX_REG_STATUS : cfg_rdata = word_t'(err_flag);
         `ERX_REG_DATAIN : cfg_rdata = word_t'(datain);
         `ERX_REG_PKTCNT : cfg_rdata = word_t'(pkt_cnt);
         default         : cfg_rdata = '0;
      endcase
   end

   // Decoder never completes and drops a packet on the same beat
   a_err_excl_pkt : assert property (@(posedge rx_lclk_div4) disable iff (rxreset)
      !(frame_err && pkt_valid))
      else $error("frame_err and pkt_valid high in the same cycle");

endmodule

`default_nettype wire

//--- src/erx_io.sv
// eLink receiver fabric-side IO with control syncs, beat pipeline, frame masking and waits
`timescale 1ns/100ps
`default_nettype none

`include "erx_cfg.svh"

module erx_io
   import erx_link_pkg::*;
   import erx_xact_pkg::*;
(
   input  wire      rx_lclk_div4,
   input  wire      rxreset,
   input  rx_ctrl_t ctrl,             // From config block, other domain
   input  rx_beat_t beat_in,          // Deserialized beat, always valid
   input  lane_t    lanes,            // Raw lane levels
   input  wire      fabric_wr_wait,
   input  wire      fabric_rd_wait,
   output rx_beat_t beat_par,         // Beat two clocks later
   output gpio_in_t datain,
   output logic     rx_wr_wait,
   output logic     rx_rd_wait
);

   logic [1:0] rxenb_sync;            // [1] first stage, [0] in use
   logic [1:0] rxgpio_sync;
   logic       rxenb;
   logic       rxgpio;

   frame_t     frame_reg;             // First stage, masked
   frame_t     frame_par;
   beat_data_t data_reg;
   beat_data_t data_par;
   gpio_in_t   datain_reg;

   assign rxenb  = rxenb_sync[0];
   assign rxgpio = rxgpio_sync[0];

   //########################################
   // Control synchronizers
   //########################################

   // Enable shifts in a one, held clear while enable is low
   always_ff @(posedge rx_lclk_div4 or posedge rxreset)
   begin
      if (rxreset)
         rxenb_sync <= '0;
      else if (!ctrl.rx_enable)
         rxenb_sync <= '0;
      else
         rxenb_sync <= {1'b1, rxenb_sync[1]};
   end

   always_ff @(posedge rx_lclk_div4 or posedge rxreset)
   begin
      if (rxreset)
         rxgpio_sync <= '0;
      else
         rxgpio_sync <= {ctrl.gpio_mode, rxgpio_sync[1]};
   end

   //########################################
   // Beat pipeline
   //########################################

   always_ff @(posedge rx_lclk_div4 or posedge rxreset)
   begin
      if (rxreset)
      begin
         frame_reg <= '0;
         frame_par <= '0;
      end
      else
      begin
         // No frames reach the decoder when off or in GPIO mode
         frame_reg <= beat_in.frame & {`ERX_FRAME_W{rxenb & ~rxgpio}};
         frame_par <= frame_reg;
      end
   end

   always_ff @(posedge rx_lclk_div4)
   begin
      data_reg <= beat_in.data;
      data_par <= data_reg;
   end

   assign beat_par = '{frame: frame_par, data: data_par};

   //########################################
   // GPIO sampling and waits
   //########################################

   always_ff @(posedge rx_lclk_div4)
   begin
      datain_reg <= {frame_par[0], lanes};   // Frame bit on top
      datain     <= datain_reg;
   end

   // Wait pins are constants from config in GPIO mode
   assign rx_rd_wait = rxgpio ? ctrl.dataout[0] : fabric_rd_wait;
   assign rx_wr_wait = rxgpio ? ctrl.dataout[1] : fabric_wr_wait;

   // Masking follows the synced enable through both beat stages
   a_frame_masked : assert property (@(posedge rx_lclk_div4) disable iff (rxreset)
      !rxenb |-> ##2 (frame_par == '0))
      else $error("frame passed while receiver disabled");

endmodule

`default_nettype wire

//--- src/erx_protocol.sv
// eLink receiver packet decoder turning framed head and body beats into packets
`timescale 1ns/100ps
`default_nettype none

`include "erx_cfg.svh"

module erx_protocol
   import erx_link_pkg::*;
   import erx_xact_pkg::*;
(
   input  wire         rx_lclk_div4,
   input  wire         rxreset,
   input  rx_beat_t    beat_par,       // From IO pipeline
   output logic        pkt_valid,      // One clock after body beat
   output erx_packet_t pkt,
   output logic        frame_err       // Dropped partial packet
);

   dec_state_t state;
   dec_state_t state_nxt;
   logic       prev_zero;               // Last frame was all zeros
   ctrl_t      head_ctrl;
   addr_t      head_dst;

   logic       frame_ones;
   logic       frame_zero;
   logic       frame_bad;
   logic       take_head;
   logic       take_body;
   logic       err_nxt;

   // Only all ones or all zeros are legal on aligned beats
   assign frame_ones = (beat_par.frame == '1);
   assign frame_zero = (beat_par.frame == '0);
   assign frame_bad  = !frame_ones && !frame_zero;

   //########################################
   // Next state
   //########################################

   always_comb
   begin
      state_nxt = state;
      take_head = 1'b0;
      take_body = 1'b0;
      err_nxt   = 1'b0;
      if (frame_bad)
      begin
         err_nxt   = 1'b1;
         state_nxt = DEC_IDLE;
      end
      else
      begin
         case (state)
            DEC_IDLE :
               if (frame_ones && prev_zero)   // Rising frame marks a head
               begin
                  take_head = 1'b1;
                  state_nxt = DEC_HEAD;
               end
            DEC_HEAD :
               if (frame_ones)
               begin
                  take_body = 1'b1;
                  state_nxt = DEC_BODY;
               end
               else
               begin
                  err_nxt   = 1'b1;           // Frame fell mid packet
                  state_nxt = DEC_IDLE;
               end
            DEC_BODY :
               if (frame_ones)                // Burst continues
               begin
                  take_head = 1'b1;
                  state_nxt = DEC_HEAD;
               end
               else
                  state_nxt = DEC_IDLE;
            default :
               state_nxt = DEC_IDLE;
         endcase
      end
   end

   //########################################
   // State and strobes
   //########################################

   always_ff @(posedge rx_lclk_div4 or posedge rxreset)
   begin
      if (rxreset)
      begin
         state     <= DEC_IDLE;
         prev_zero <= 1'b0;
         pkt_valid <= 1'b0;
         frame_err <= 1'b0;
      end
      else
      begin
         state     <= state_nxt;
         prev_zero <= frame_zero;
         pkt_valid <= take_body;
         frame_err <= err_nxt;
      end
   end

   // Packet fields, qualified by pkt_valid
   always_ff @(posedge rx_lclk_div4)
   begin
      if (take_head)
      begin
         head_ctrl <= beat_par.data[`ERX_CTRL_MSB:`ERX_CTRL_LSB];
         head_dst  <= beat_par.data[`ERX_DST_MSB:`ERX_DST_LSB];
      end
      if (take_body)
         pkt <= '{ctrl    : head_ctrl,
                  dstaddr : head_dst,
                  data    : beat_par.data[`ERX_DATA_MSB:`ERX_DATA_LSB],
                  srcaddr : beat_par.data[`ERX_SRC_MSB:`ERX_SRC_LSB]};
   end

   // A packet takes two beats, so strobes never touch
   a_pkt_single : assert property (@(posedge rx_lclk_div4) disable iff (rxreset)
      pkt_valid |=> !pkt_valid)
      else $error("pkt_valid high two cycles in a row");

endmodule

`default_nettype wire

//--- src/erx.sv
// eLink receiver fabric top joining IO pipeline, packet decoder and config block
`timescale 1ns/100ps
`default_nettype none

module erx
   import erx_link_pkg::*;
   import erx_xact_pkg::*;
(
   input  wire         rx_lclk_div4,
   input  wire         rxreset,
   input  rx_beat_t    beat_in,
   input  lane_t       lanes,
   input  wire         fabric_wr_wait,
   input  wire         fabric_rd_wait,
   input  wire         cfg_write,
   input  reg_addr_t   cfg_addr,
   input  word_t       cfg_wdata,
   output word_t       cfg_rdata,
   output logic        pkt_valid,
   output erx_packet_t pkt,
   output logic        rx_wr_wait,
   output logic        rx_rd_wait
);

   rx_ctrl_t ctrl;        // Config to IO
   rx_beat_t beat_par;    // IO to decoder
   gpio_in_t datain;      // IO to config readback
   logic     frame_err;   // Decoder to status

   erx_ecfg i_ecfg (
      .rx_lclk_div4 (rx_lclk_div4),
      .rxreset      (rxreset),
      .cfg_write    (cfg_write),
      .cfg_addr     (cfg_addr),
      .cfg_wdata    (cfg_wdata),
      .cfg_rdata    (cfg_rdata),
      .datain       (datain),
      .pkt_valid    (pkt_valid),
      .frame_err    (frame_err),
      .ctrl         (ctrl)
   );

   erx_io i_io (
      .rx_lclk_div4   (rx_lclk_div4),
      .rxreset        (rxreset),
      .ctrl           (ctrl),
      .beat_in        (beat_in),
      .lanes          (lanes),
      .fabric_wr_wait (fabric_wr_wait),
      .fabric_rd_wait (fabric_rd_wait),
      .beat_par       (beat_par),
      .datain         (datain),
      .rx_wr_wait     (rx_wr_wait),
      .rx_rd_wait     (rx_rd_wait)
   );

   erx_protocol i_protocol (
      .rx_lclk_div4 (rx_lclk_div4),
      .rxreset      (rxreset),
      .beat_par     (beat_par),
      .pkt_valid    (pkt_valid),
      .pkt          (pkt),
      .frame_err    (frame_err)
   );

endmodule

`default_nettype wire

//--- dv/erx_tb.sv
// eLink receiver testbench driving beats and config writes, checking decoded packets and status
`timescale 1ns/100ps
`default_nettype none

`include "erx_cfg.svh"

module erx_tb
   import erx_link_pkg::*;
   import erx_xact_pkg::*;
();

   logic        rx_lclk_div4;
   logic        rxreset;
   rx_beat_t    beat_in;
   lane_t       lanes;
   logic        fabric_wr_wait;
   logic        fabric_rd_wait;
   logic        cfg_write;
   reg_addr_t   cfg_addr;
   word_t       cfg_wdata;
   word_t       cfg_rdata;
   logic        pkt_valid;
   erx_packet_t pkt;
   logic        rx_wr_wait;
   logic        rx_rd_wait;

   erx_packet_t exp_q[$];             // Built from driven beat fields
   erx_packet_t rx_q[$];              // Seen at the DUT output
   int          errors;
   int          checks;
   int          tests;
   int          errs_at_start;

   erx i_dut (.*);

   always #50 rx_lclk_div4 = ~rx_lclk_div4;   // 100 ns period

   // Strobe is stable mid cycle
   always @(negedge rx_lclk_div4)
      if (pkt_valid === 1'b1)
         rx_q.push_back(pkt);

   //########################################
   // Helpers
   //########################################

   task automatic next_cycle;
      @(posedge rx_lclk_div4);
      #1;                              // Drive just after the edge
   endtask

   task automatic check(input string name, input logic [127:0] exp, input logic [127:0] act);
      checks++;
      if (exp !== act)
      begin
         errors++;
         $display("FAILED t=%0t %s expected %0h actual %0h", $time, name, exp, act);
      end
   endtask

   task automatic cfg_wr(input reg_addr_t a, input word_t d);
      cfg_write = 1'b1;
      cfg_addr  = a;
      cfg_wdata = d;
      next_cycle;                      // Lands on this edge
      cfg_write = 1'b0;
   endtask

   task automatic cfg_rd(input reg_addr_t a, output word_t d);
      cfg_addr = a;
      #1;                              // Read mux is combinational
      d = cfg_rdata;
   endtask

   task automatic send_idle(input int n);
      beat_in.frame = '0;
      repeat (n)
      begin
         beat_in.data = beat_data_t'({$urandom, $urandom});
         next_cycle;
      end
   endtask

   // Head then body, frame high on both; optionally clear enable with the head
   task automatic send_pair(input bit keep, input bit drop_enable);
      ctrl_t       c;
      addr_t       d;
      word_t       w;
      addr_t       s;
      erx_packet_t p;
      c = ctrl_t'($urandom);
      d = addr_t'($urandom);
      w = word_t'($urandom);
      s = addr_t'($urandom);
      p.ctrl    = c;
      p.dstaddr = d;
      p.data    = w;
      p.srcaddr = s;
      if (drop_enable)
      begin
         cfg_write = 1'b1;
         cfg_addr  = `ERX_REG_CTRL;
         cfg_wdata = '0;
      end
      beat_in.frame = '1;
      beat_in.data  = {c, d, 24'($urandom)};   // Low bits unused
      next_cycle;
      cfg_write     = 1'b0;
      beat_in.data  = {w, s};
      next_cycle;
      if (keep)
         exp_q.push_back(p);
   endtask

   task automatic wait_packets(input int n, input int limit);
      int cnt;
      cnt = 0;
      while (rx_q.size() < n && cnt < limit)
      begin
         next_cycle;
         cnt++;
      end
      if (rx_q.size() < n)
      begin
         errors++;
         $display("timeout at t=%0t waiting for %0d packets, only %0d arrived",
                  $time, n, rx_q.size());
      end
   endtask

   task automatic compare_packets;
      erx_packet_t e;
      erx_packet_t a;
      check("packet count", exp_q.size(), rx_q.size());
      while (exp_q.size() > 0 && rx_q.size() > 0)
      begin
         e = exp_q.pop_front();
         a = rx_q.pop_front();
         check("pkt.ctrl", e.ctrl, a.ctrl);
         check("pkt.dstaddr", e.dstaddr, a.dstaddr);
         check("pkt.data", e.data, a.data);
         check("pkt.srcaddr", e.srcaddr, a.srcaddr);
      end
      exp_q.delete();
      rx_q.delete();
   endtask

   task automatic start_test;
      tests++;
      errs_at_start = errors;
   endtask

   task automatic end_test(input string name);
      $display("test %0d %s: %s", tests, name, (errors == errs_at_start) ? "pass" : "fail");
   endtask

   //########################################
   // Directed tests
   //########################################

   task automatic disabled_ignores_frames;
      word_t rd;
      start_test;
      for (int k = 0; k < 4; k++)
      begin
         fabric_wr_wait = k[1];
         fabric_rd_wait = k[0];
         #1;
         check("rx_wr_wait", k[1], rx_wr_wait);   // Fabric passes through
         check("rx_rd_wait", k[0], rx_rd_wait);
      end
      cfg_rd(`ERX_REG_CTRL, rd);
      check("CTRL", 0, rd);
      send_idle(2);
      send_pair(1'b0, 1'b0);
      send_idle(1);
      send_pair(1'b0, 1'b0);
      send_idle(6);
      check("packets while disabled", 0, rx_q.size());
      rx_q.delete();
      end_test("disabled");
   endtask

   task automatic decode_packets;
      word_t rd;
      start_test;
      cfg_wr(`ERX_REG_PKTCNT, '0);
      cfg_wr(`ERX_REG_CTRL, 32'h1);
      send_idle(4);                    // Enable sync settles
      send_pair(1'b1, 1'b0);
      send_idle(1);
      send_pair(1'b1, 1'b0);
      send_idle(2);
      repeat (4)
         send_pair(1'b1, 1'b0);        // Burst, frame stays high
      send_idle(1);
      wait_packets(6, 20);
      send_idle(3);
      compare_packets;
      cfg_rd(`ERX_REG_PKTCNT, rd);
      check("PKTCNT", 6, rd);
      end_test("decode");
   endtask

   task automatic frame_errors;
      word_t rd;
      start_test;
      cfg_wr(`ERX_REG_STATUS, 32'h1);
      send_idle(1);
      beat_in.frame = 8'h0F;           // Neither all ones nor zeros
      next_cycle;
      send_idle(5);
      cfg_rd(`ERX_REG_STATUS, rd);
      check("STATUS after bad frame", 1, rd[0]);
      cfg_wr(`ERX_REG_STATUS, 32'h1);
      cfg_rd(`ERX_REG_STATUS, rd);
      check("STATUS after clear", 0, rd[0]);
      beat_in.frame = '1;              // Head only
      beat_in.data  = beat_data_t'({$urandom, $urandom});
      next_cycle;
      send_idle(5);
      cfg_rd(`ERX_REG_STATUS, rd);
      check("STATUS after early fall", 1, rd[0]);
      check("packets from bad frames", 0, rx_q.size());
      cfg_wr(`ERX_REG_STATUS, 32'h1);
      cfg_rd(`ERX_REG_STATUS, rd);
      check("STATUS after second clear", 0, rd[0]);
      send_pair(1'b1, 1'b0);           // Decoder recovers
      send_idle(1);
      wait_packets(1, 10);
      compare_packets;
      end_test("frame error");
   endtask

   task automatic gpio_mode_waits;
      word_t rd;
      lane_t lv;
      start_test;
      cfg_wr(`ERX_REG_CTRL, 32'hB);   // Enable, GPIO, dataout 2'b10
      send_idle(4);
      for (int k = 0; k < 4; k++)
      begin
         fabric_wr_wait = k[1];
         fabric_rd_wait = k[0];
         #1;
         check("rx_wr_wait gpio", 1'b1, rx_wr_wait);
         check("rx_rd_wait gpio", 1'b0, rx_rd_wait);
      end
      cfg_wr(`ERX_REG_CTRL, 32'h7);   // dataout 2'b01
      for (int k = 0; k < 4; k++)
      begin
         fabric_wr_wait = k[1];
         fabric_rd_wait = k[0];
         #1;
         check("rx_wr_wait gpio", 1'b0, rx_wr_wait);
         check("rx_rd_wait gpio", 1'b1, rx_rd_wait);
      end
      send_pair(1'b0, 1'b0);
      send_pair(1'b0, 1'b0);
      lv    = lane_t'($urandom);
      lanes = lv;
      send_idle(5);
      check("packets in gpio mode", 0, rx_q.size());
      cfg_rd(`ERX_REG_DATAIN, rd);
      check("DATAIN", {1'b0, lv}, rd); // Frame masked, top bit low
      rx_q.delete();
      cfg_wr(`ERX_REG_CTRL, 32'h1);   // Back to decoding
      send_idle(4);
      end_test("gpio");
   endtask

   task automatic disable_mid_burst;
      start_test;
      send_pair(1'b1, 1'b0);
      send_pair(1'b1, 1'b0);
      send_pair(1'b1, 1'b1);           // Sync delay still lets this pair through
      send_pair(1'b0, 1'b0);
      send_pair(1'b0, 1'b0);
      send_idle(1);
      wait_packets(3, 10);
      send_idle(6);
      compare_packets;
      cfg_wr(`ERX_REG_CTRL, 32'h1);
      send_idle(4);
      send_pair(1'b1, 1'b0);
      send_idle(1);
      wait_packets(1, 10);
      compare_packets;
      end_test("disable mid burst");
   endtask

   //########################################
   // Run
   //########################################

   initial
   begin
      rx_lclk_div4   = 1'b0;
      rxreset        = 1'b1;
      beat_in        = '0;
      lanes          = '0;
      fabric_wr_wait = 1'b0;
      fabric_rd_wait = 1'b0;
      cfg_write      = 1'b0;
      cfg_addr       = '0;
      cfg_wdata      = '0;
      errors         = 0;
      checks         = 0;
      tests          = 0;
      void'($urandom(32'h6ff5ad2f));
      repeat (8)
         next_cycle;
      rxreset = 1'b0;
      next_cycle;
      disabled_ignores_frames;
      decode_packets;
      frame_errors;
      gpio_mode_waits;
      disable_mid_burst;
      $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
      if (errors == 0)
         $display("NO ERRORS");
      else
         $display("ERRORS FOUND");
      $finish;
   end

   // Whole run limit
   initial
   begin
      #(100 * 5000);
      $display("simulation ran past its time limit");
      $display("ERRORS FOUND");
      $finish;
   end

endmodule

`default_nettype wire

//--- files.f
+incdir+src
src/erx_link_pkg.sv
src/erx_xact_pkg.sv
src/erx_ecfg.sv
src/erx_io.sv
src/erx_protocol.sv
src/erx.sv
dv/erx_tb.sv
